/* Bender.yml */
package:
  name: conv_coproc

sources:
  - files:
      - common/conv_pkg.sv
      - common/conv_lane_if.sv
      - conv_lane/conv_rgb.sv
      - conv_lane/conv_unit.sv
      - conv_lane/conv_lane.sv
      - design/conv_results.sv
      - design/conv_dispatch.sv
      - design/conv_top.sv
  - target: test
    files:
      - testbench/conv_chk.sv
      - testbench/conv_tb.sv

/* common/conv_lane_if.sv */
`timescale 1ns/1ps

interface convLaneIf import convPkg::*; ();

	// launch side, start is a single-cycle pulse
	logic start;
	convOpT op;
	regWordT src;

	// completion side, result valid with done
	logic done;
	regWordT result;

	modport dispatch (
		output start,
		output op,
		output src
	);

	modport lane (
		input start,
		input op,
		input src,
		output done,
		output result
	);

	modport collect (
		input start,
		input done,
		input result
	);

endinterface

/* common/conv_pkg.sv */
package convPkg;

	// register and bus widths
	localparam int RegWidth = 64;
	localparam int OpWidth = 6;
	localparam int AdrWidth = 4;

	// lane count, also sets the lane field of the address
	localparam int NumLanes = 4;

	typedef logic [RegWidth-1:0] regWordT;
	typedef logic [OpWidth-1:0] convOpT;
	typedef logic [$clog2(NumLanes)-1:0] laneIdxT;
	typedef logic [1:0] regSelT;

	// register selects, address bits 1..0
	localparam regSelT RegOp = 2'd0;
	localparam regSelT RegSrc = 2'd1;
	localparam regSelT RegResult = 2'd2;
	localparam regSelT RegStatus = 2'd3;

	// move and integer forms
	localparam convOpT OpMov = 6'd0;
	localparam convOpT OpNot = 6'd1;
	localparam convOpT OpExtSB = 6'd2;
	localparam convOpT OpExtSW = 6'd3;
	localparam convOpT OpExtSL = 6'd4;
	localparam convOpT OpExtUB = 6'd5;
	localparam convOpT OpExtUW = 6'd6;
	localparam convOpT OpExtUL = 6'd7;

	// immediate high parts
	localparam convOpT OpLdiHi = 6'd8;
	localparam convOpT OpLdiQHi32 = 6'd9;

	// fp sign bit only
	localparam convOpT OpFNeg = 6'd10;
	localparam convOpT OpFAbs = 6'd11;

	// pixel formats
	localparam convOpT OpRgb5Pck32 = 6'd12;
	localparam convOpT OpRgb5Upck32 = 6'd13;
	localparam convOpT OpRgb32Pck64 = 6'd14;
	localparam convOpT OpRgb32Upck64 = 6'd15;

	// bus cycle of the dispatcher
	typedef enum logic {
		Idle,
		Ack
	} busStateE;

endpackage

/* conv_lane/conv_lane.sv */
`timescale 1ns/1ps

module convLane import convPkg::*; (
	input logic clk,
	input logic rstN,
	convLaneIf.lane laneIf
);

	logic s1Valid;
	convOpT s1Op;
	regWordT s1Src;
	logic s2Valid;
	regWordT s2Result;
	regWordT convOut;

	// valid bits walk down the pipe, one item per stage
	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			s1Valid <= 1'b0;
			s2Valid <= 1'b0;
			s2Result <= '0;
		end else begin
			s1Valid <= laneIf.start;
			s2Valid <= s1Valid;
			if (s1Valid)
				s2Result <= convOut;
		end
	end

	// operands latched on launch
	always_ff @(posedge clk) begin
		if (laneIf.start) begin
			s1Op <= laneIf.op;
			s1Src <= laneIf.src;
		end
	end

	convUnit uConv (
		.op(s1Op),
		.src(s1Src),
		.result(convOut)
	);

	assign laneIf.done = s2Valid;
	assign laneIf.result = s2Result;

endmodule

/* conv_lane/conv_rgb.sv */
`timescale 1ns/1ps

module convRgb import convPkg::*; (
	input regWordT src,
	output regWordT rgb5Pck,
	output regWordT rgb5Upck,
	output regWordT rgb32Pck,
	output regWordT rgb32Upck
);

	logic [7:0] alpha5;

	// widen a 5-bit channel by repeating its top bits
	function automatic logic [7:0] expand5(input logic [4:0] chan);
		return {chan, chan[4:2]};
	endfunction

	// argb8888 to rgb555, translucent pixels keep 3 alpha bits
	always_comb begin
		rgb5Pck = {48'h0, 1'b0, src[23:19], src[15:11], src[7:3]};
		if (src[31:28] != 4'hF) begin
			rgb5Pck[15] = 1'b1;
			rgb5Pck[10] = src[31];
			rgb5Pck[5] = src[30];
			rgb5Pck[0] = src[29];
		end
	end

	// alpha rebuilt from the low bit of each channel
	assign alpha5 = src[15] ? {src[10], src[5], src[0], 5'b00000} : 8'hFF;

	assign rgb5Upck = {
		32'h0,
		alpha5,
		expand5(src[14:10]),
		expand5(src[9:5]),
		expand5(src[4:0])
	};

	// high byte of each 16-bit channel
	assign rgb32Pck = {32'h0, src[63:56], src[47:40], src[31:24], src[15:8]};

	// each byte doubled to fill 16 bits
	assign rgb32Upck = {
		src[31:24], src[31:24],
		src[23:16], src[23:16],
		src[15:8], src[15:8],
		src[7:0], src[7:0]
	};

endmodule

/* conv_lane/conv_unit.sv */
`timescale 1ns/1ps

module convUnit import convPkg::*; (
	input convOpT op,
	input regWordT src,
	output regWordT result
);

	regWordT rgb5Pck;
	regWordT rgb5Upck;
	regWordT rgb32Pck;
	regWordT rgb32Upck;

	convRgb uRgb (
		.src(src),
		.rgb5Pck(rgb5Pck),
		.rgb5Upck(rgb5Upck),
		.rgb32Pck(rgb32Pck),
		.rgb32Upck(rgb32Upck)
	);

	always_comb begin
		case (op)
			OpMov: begin
				result = src;
			end
			OpNot: begin
				result = ~src;
			end

			// sign extension
			OpExtSB: begin
				result = {{56{src[7]}}, src[7:0]};
			end
			OpExtSW: begin
				result = {{48{src[15]}}, src[15:0]};
			end
			OpExtSL: begin
				result = {{32{src[31]}}, src[31:0]};
			end

			// zero extension
			OpExtUB: begin
				result = {56'h0, src[7:0]};
			end
			OpExtUW: begin
				result = {48'h0, src[15:0]};
			end
			OpExtUL: begin
				result = {32'h0, src[31:0]};
			end

			// immediate high forms
			OpLdiHi: begin
				result = {src[41:0], 22'h0};
			end
			OpLdiQHi32: begin
				result = {src[31:0], 32'h0};
			end

			// only the sign of a double is touched
			OpFNeg: begin
				result = {~src[63], src[62:0]};
			end
			OpFAbs: begin
				result = {1'b0, src[62:0]};
			end

			OpRgb5Pck32: begin
				result = rgb5Pck;
			end
			OpRgb5Upck32: begin
				result = rgb5Upck;
			end
			OpRgb32Pck64: begin
				result = rgb32Pck;
			end
			OpRgb32Upck64: begin
				result = rgb32Upck;
			end

			// unused codes read back as zero
			default: begin
				result = '0;
			end
		endcase
	end

endmodule

/* design/conv_dispatch.sv */
`timescale 1ns/1ps

module convDispatch import convPkg::*; (
	input logic clk,
	input logic rstN,
	input logic wbCyc,
	input logic wbStb,
	input logic wbWe,
	input logic [AdrWidth-1:0] wbAdr,
	input regWordT wbDatI,
	output logic wbAck,
	output regWordT wbDatO,
	convLaneIf.dispatch lanes [NumLanes],
	output laneIdxT rdLane,
	output regSelT rdSel,
	input regWordT rdData
);

	busStateE state;
	logic accept;
	laneIdxT adrLane;
	regSelT adrSel;
	regWordT srcReg;

	// request only counts while idle, ack is low there
	assign accept = (state == Idle) && wbCyc && wbStb;
	assign adrSel = wbAdr[1:0];
	assign adrLane = wbAdr[3:2];

	// read path goes straight to the result bank
	assign rdLane = adrLane;
	assign rdSel = adrSel;

	assign wbAck = (state == Ack);

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			state <= Idle;
			wbDatO <= '0;
		end else begin
			case (state)
				Idle: begin
					if (accept) begin
						state <= Ack;
						if (!wbWe)
							wbDatO <= rdData;
					end
				end
				default: begin
					state <= Idle;
				end
			endcase
		end
	end

	// shared source holder, only one lane launches per cycle
	always_ff @(posedge clk) begin
		if (accept && wbWe && adrSel == RegSrc)
			srcReg <= wbDatI;
	end

	for (genvar i = 0; i < NumLanes; i++) begin : gLane
		logic hit;
		logic startReg;
		convOpT opReg;

		assign hit = accept && wbWe && (adrLane == laneIdxT'(i));

		always_ff @(posedge clk or negedge rstN) begin
			if (!rstN) begin
				startReg <= 1'b0;
				opReg <= '0;
			end else begin
				// start rises with ack
				startReg <= hit && (adrSel == RegSrc);
				if (hit && adrSel == RegOp)
					opReg <= wbDatI[OpWidth-1:0];
			end
		end

		assign lanes[i].start = startReg;
		assign lanes[i].op = opReg;
		assign lanes[i].src = srcReg;
	end

endmodule

/* design/conv_results.sv */
`timescale 1ns/1ps

module convResults import convPkg::*; (
	input logic clk,
	input logic rstN,
	convLaneIf.collect lanes [NumLanes],
	input laneIdxT rdLane,
	input regSelT rdSel,
	output regWordT rdData
);

	regWordT laneResult [NumLanes];
	logic [NumLanes-1:0] doneFlag;

	for (genvar i = 0; i < NumLanes; i++) begin : gLane
		// items launched but not yet done, at most 2 in flight
		logic [1:0] pendCnt;
		logic flag;
		regWordT capReg;

		always_ff @(posedge clk or negedge rstN) begin
			if (!rstN) begin
				pendCnt <= 2'd0;
				flag <= 1'b0;
				capReg <= '0;
			end else begin
				case ({lanes[i].start, lanes[i].done})
					2'b10: pendCnt <= pendCnt + 2'd1;
					2'b01: pendCnt <= pendCnt - 2'd1;
					default: pendCnt <= pendCnt;
				endcase
				if (lanes[i].done)
					capReg <= lanes[i].result;
				// flag only when the newest launch has finished
				if (lanes[i].start)
					flag <= 1'b0;
				else if (lanes[i].done && pendCnt == 2'd1)
					flag <= 1'b1;
			end
		end

		assign doneFlag[i] = flag;
		assign laneResult[i] = capReg;
	end

	always_comb begin
		case (rdSel)
			RegResult: rdData = laneResult[rdLane];
			RegStatus: rdData = {{(RegWidth-NumLanes){1'b0}}, doneFlag};
			default: rdData = '0;
		endcase
	end

endmodule

/* design/conv_top.sv */
`timescale 1ns/1ps

module convTop import convPkg::*; (
	input logic clk,
	input logic rstN,
	input logic wbCyc,
	input logic wbStb,
	input logic wbWe,
	input logic [AdrWidth-1:0] wbAdr,
	input regWordT wbDatI,
	output regWordT wbDatO,
	output logic wbAck
);

	convLaneIf laneIf [NumLanes] ();

	laneIdxT rdLane;
	regSelT rdSel;
	regWordT rdData;

	convDispatch uDispatch (
		.clk(clk),
		.rstN(rstN),
		.wbCyc(wbCyc),
		.wbStb(wbStb),
		.wbWe(wbWe),
		.wbAdr(wbAdr),
		.wbDatI(wbDatI),
		.wbAck(wbAck),
		.wbDatO(wbDatO),
		.lanes(laneIf),
		.rdLane(rdLane),
		.rdSel(rdSel),
		.rdData(rdData)
	);

	for (genvar i = 0; i < NumLanes; i++) begin : gLane
		convLane uLane (
			.clk(clk),
			.rstN(rstN),
			.laneIf(laneIf[i])
		);
	end

	convResults uResults (
		.clk(clk),
		.rstN(rstN),
		.lanes(laneIf),
		.rdLane(rdLane),
		.rdSel(rdSel),
		.rdData(rdData)
	);

endmodule

/* testbench/conv_chk.sv */
`timescale 1ns/1ps

module convChk import convPkg::*; (
	input logic clk,
	input logic rstN,
	input logic wbCyc,
	input logic wbStb,
	input logic wbAck,
	input logic [NumLanes-1:0] laneStart,
	input logic [NumLanes-1:0] laneDone
);

	// count of failed assertions
	int errCount;

	initial errCount = 0;

	ackPulse: assert property (@(posedge clk) disable iff (!rstN) wbAck |=> !wbAck)
	else begin
		$error("ack held for more than one cycle");
		errCount++;
	end

	ackAfterReq: assert property (@(posedge clk) disable iff (!rstN)
		wbAck |-> $past(wbCyc && wbStb))
	else begin
		$error("ack without a request in the previous cycle");
		errCount++;
	end

	resetQuiet: assert property (@(posedge clk) !rstN |-> (laneStart == '0 && laneDone == '0))
	else begin
		$error("lane start or done active during reset");
		errCount++;
	end

	for (genvar i = 0; i < NumLanes; i++) begin : gLane
		// latency fixed at 2 in both directions
		startDone: assert property (@(posedge clk) disable iff (!rstN)
			laneStart[i] |-> ##2 laneDone[i])
		else begin
			$error("lane done missing 2 cycles after start");
			errCount++;
		end
		doneStart: assert property (@(posedge clk) disable iff (!rstN)
			laneDone[i] |-> $past(laneStart[i], 2))
		else begin
			$error("lane done without a start 2 cycles before");
			errCount++;
		end
	end

endmodule

bind convTop convChk uChk (
	.clk(clk),
	.rstN(rstN),
	.wbCyc(wbCyc),
	.wbStb(wbStb),
	.wbAck(wbAck),
	.laneStart({laneIf[3].start, laneIf[2].start, laneIf[1].start, laneIf[0].start}),
	.laneDone({laneIf[3].done, laneIf[2].done, laneIf[1].done, laneIf[0].done})
);

/* testbench/conv_tb.sv */
`timescale 1ns/1ps

module convTb import convPkg::*; ();

	localparam int AckLimit = 8;
	localparam int PollLimit = 20;

	logic clk;
	logic rstN;
	logic wbCyc;
	logic wbStb;
	logic wbWe;
	logic [AdrWidth-1:0] wbAdr;
	regWordT wbDatI;
	regWordT wbDatO;
	logic wbAck;
	logic [31:0] lfsrState;

	convTop UUT (.*);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	task automatic reportFail(input string msg);
		$display("%s", msg);
		$display("Verification failed");
		$fatal(1);
	endtask

	task automatic checkValue(input string name, input regWordT exp, input regWordT got);
		assert (got === exp)
		else reportFail($sformatf("Error at %0t: %s expected %h got %h", $time, name, exp, got));
	endtask

	// failures of the bound assertions end the run too
	always @(negedge clk) begin
		if (UUT.uChk.errCount != 0)
			reportFail("an assertion in the bound checker failed");
	end

	// galois taps for x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] lfsrStep(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
	endfunction

	task automatic nextWord(output regWordT w);
		w = '0;
		for (int b = 0; b < RegWidth; b++) begin
			lfsrState = lfsrStep(lfsrState);
			w = {w[RegWidth-2:0], lfsrState[0]};
		end
	endtask

	// expected result of each operation
	function automatic regWordT refConv(input convOpT op, input regWordT src);
		regWordT res;
		logic [15:0] p;
		logic [4:0] ch;
		res = '0;
		case (op)
			OpMov: res = src;
			OpNot: res = ~src;
			OpExtSB: res = 64'($signed(src[7:0]));
			OpExtSW: res = 64'($signed(src[15:0]));
			OpExtSL: res = 64'($signed(src[31:0]));
			OpExtUB: res = src & 64'hFF;
			OpExtUW: res = src & 64'hFFFF;
			OpExtUL: res = src & 64'hFFFF_FFFF;
			OpLdiHi: res = src << 22;
			OpLdiQHi32: res = src << 32;
			OpFNeg: res = src ^ (64'd1 << 63);
			OpFAbs: res = src & ~(64'd1 << 63);
			OpRgb5Pck32: begin
				p = {1'b0, src[23:19], src[15:11], src[7:3]};
				if (src[31:28] != 4'hF)
					p = (p & ~16'h0421) | 16'h8000 | {5'd0, src[31], 4'd0, src[30], 4'd0, src[29]};
				res = 64'(p);
			end
			OpRgb5Upck32: begin
				for (int k = 0; k < 3; k++) begin
					ch = src[5*k +: 5];
					res[8*k +: 8] = {ch, ch[4:2]};
				end
				res[31:24] = src[15] ? {src[10], src[5], src[0], 5'b0} : 8'hFF;
			end
			OpRgb32Pck64: for (int k = 0; k < 4; k++) res[8*k +: 8] = src[16*k+8 +: 8];
			OpRgb32Upck64: for (int k = 0; k < 4; k++) res[16*k +: 16] = {2{src[8*k +: 8]}};
			default: res = '0;
		endcase
		return res;
	endfunction

	// one classic bus cycle driven and sampled on falling edges
	task automatic busCycle(input logic we, input int lane, input regSelT sel,
			input regWordT dat, output regWordT rd);
		int waitCnt;
		logic gotAck;
		@(negedge clk);
		wbCyc = 1'b1;
		wbStb = 1'b1;
		wbWe = we;
		wbAdr = {laneIdxT'(lane), sel};
		wbDatI = dat;
		waitCnt = 0;
		do begin
			@(negedge clk);
			waitCnt++;
		end while (!wbAck && waitCnt < AckLimit);
		gotAck = wbAck;
		rd = wbDatO;
		wbCyc = 1'b0;
		wbStb = 1'b0;
		wbWe = 1'b0;
		assert (gotAck) else reportFail("bus cycle timed out waiting for acknowledge");
	endtask

	task automatic waitDone(input logic [NumLanes-1:0] mask);
		regWordT st;
		int polls;
		polls = 0;
		do begin
			busCycle(1'b0, 0, RegStatus, '0, st);
			polls++;
		end while ((st[NumLanes-1:0] & mask) != mask && polls < PollLimit);
		assert ((st[NumLanes-1:0] & mask) == mask)
		else reportFail("lane done flag was never set in the status word");
	endtask

	task automatic launchCheck(input int lane, input convOpT op, input regWordT src);
		regWordT rd;
		busCycle(1'b1, lane, RegOp, regWordT'(op), rd);
		busCycle(1'b1, lane, RegSrc, src, rd);
		waitDone(NumLanes'(1) << lane);
		busCycle(1'b0, lane, RegResult, '0, rd);
		checkValue($sformatf("wbDatO lane %0d op %0d", lane, op), refConv(op, src), rd);
	endtask

	initial begin
		regWordT rd;
		regWordT src;
		regWordT srcs [NumLanes];
		convOpT ops [NumLanes];
		rstN = 1'b0;
		wbCyc = 1'b0;
		wbStb = 1'b0;
		wbWe = 1'b0;
		wbAdr = '0;
		wbDatI = '0;
		lfsrState = 32'd71375;
		repeat (8) @(posedge clk);
		@(negedge clk);
		rstN = 1'b1;

		// quiet bus and empty status after reset
		for (int n = 0; n < 4; n++) begin
			@(negedge clk);
			checkValue("wbAck", '0, regWordT'(wbAck));
		end
		busCycle(1'b0, 0, RegStatus, '0, rd);
		checkValue("wbDatO status", '0, rd);

		for (int op = 0; op < 16; op++) begin
			nextWord(src);
			launchCheck(0, convOpT'(op), src);
		end

		// rgb555 opaque and translucent corners
		launchCheck(1, OpRgb5Pck32, 64'h1234_5678_F3A5_C7E9);
		launchCheck(1, OpRgb5Pck32, 64'h1234_5678_53A5_C7E9);
		nextWord(src);
		launchCheck(1, OpRgb5Upck32, {src[63:16], 16'h3D6B});
		launchCheck(1, OpRgb5Upck32, {src[63:16], 16'hBD6B});

		ops = '{OpExtSW, OpRgb32Upck64, OpLdiHi, OpFNeg};
		for (int i = 0; i < NumLanes; i++) begin
			nextWord(srcs[i]);
			busCycle(1'b1, i, RegOp, regWordT'(ops[i]), rd);
		end
		for (int i = 0; i < NumLanes; i++)
			busCycle(1'b1, i, RegSrc, srcs[i], rd);
		waitDone('1);
		for (int i = 0; i < NumLanes; i++) begin
			busCycle(1'b0, i, RegResult, '0, rd);
			checkValue($sformatf("wbDatO lane %0d", i), refConv(ops[i], srcs[i]), rd);
		end

		// relaunch lane 2 with an unused code
		nextWord(src);
		busCycle(1'b1, 2, RegOp, 64'd37, rd);
		busCycle(1'b1, 2, RegSrc, src, rd);
		busCycle(1'b0, 0, RegStatus, '0, rd);
		checkValue("wbDatO status bit 2", '0, regWordT'(rd[2]));
		waitDone(4'b0100);
		busCycle(1'b0, 2, RegResult, '0, rd);
		checkValue("wbDatO lane 2 unused op", '0, rd);

		$display("Verification passed");
		$finish;
	end

endmodule

/* vlog.f */
common/conv_pkg.sv
common/conv_lane_if.sv
conv_lane/conv_rgb.sv
conv_lane/conv_unit.sv
conv_lane/conv_lane.sv
design/conv_results.sv
design/conv_dispatch.sv
design/conv_top.sv
testbench/conv_chk.sv
testbench/conv_tb.sv
